// File: common/tile_conf_pkg.sv
`default_nettype none

package tile_conf_pkg;

  // --------------------
  // Dispatch and issue
  // --------------------
  localparam int DISP_SIZE    = 2;
  localparam int ALU_INST_NUM = 2;

  // Rank of a slot among the ALU slots of one group
  localparam int DISP_CNT_W = $clog2(DISP_SIZE + 1);

  // --------------------
  // Datapath
  // --------------------
  localparam int XLEN        = 32;
  localparam int PHY_REG_NUM = 32;
  localparam int RNID_W      = $clog2(PHY_REG_NUM);
  localparam int CMT_ID_W    = 6;

  // --------------------
  // Register file ports
  // --------------------
  // Two read ports per ALU pipe
  localparam int RD_PORT_NUM = ALU_INST_NUM * 2;
  // One write port per ALU pipe, load return on the last port
  localparam int WR_PORT_NUM = ALU_INST_NUM + 1;

endpackage

`default_nettype wire

// File: common/tile_pkg.sv
`default_nettype none

package tile_pkg;

  import tile_conf_pkg::*;

  typedef logic [RNID_W-1:0]   rnid_t;
  typedef logic [CMT_ID_W-1:0] cmt_id_t;
  typedef logic [XLEN-1:0]     data_t;

  // --------------------
  // Encodings
  // --------------------
  typedef enum logic [2:0] {
    CAT_ALU,
    CAT_LD,
    CAT_ST,
    CAT_BR,
    CAT_CSU
  } inst_cat_t;

  typedef enum logic [2:0] {
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_SLT
  } alu_op_t;

  // --------------------
  // Dispatch
  // --------------------
  typedef struct packed {
    logic      valid;
    logic      illegal;
    inst_cat_t cat;
    alu_op_t   op;
    rnid_t     rs1;
    rnid_t     rs2;
    rnid_t     rd;
    cmt_id_t   cmt_id;
  } disp_inst_t;

  typedef disp_inst_t [DISP_SIZE-1:0] disp_grp_t;

  // Instruction as seen by one ALU pipe
  typedef struct packed {
    logic    valid;
    alu_op_t op;
    rnid_t   rs1;
    rnid_t   rs2;
    rnid_t   rd;
    cmt_id_t cmt_id;
  } alu_issue_t;

  // --------------------
  // Results
  // --------------------
  typedef struct packed {
    logic  valid;
    rnid_t rd;
    data_t data;
  } phy_wr_t;

  typedef struct packed {
    logic    valid;
    cmt_id_t cmt_id;
    rnid_t   rd;
    data_t   data;
  } done_rpt_t;

endpackage

`default_nettype wire

// File: logic/disp_router.sv
`timescale 1ns/1ps
`default_nettype none

module disp_router (
  input  logic                  i_clk,
  input  logic                  i_rst_n,
  input  tile_pkg::disp_grp_t   i_disp,
  output tile_pkg::alu_issue_t  o_issue [tile_conf_pkg::ALU_INST_NUM]
);

  import tile_pkg::*;
  import tile_conf_pkg::*;

  logic [DISP_SIZE-1:0]  w_alu_slot;
  logic [DISP_CNT_W-1:0] w_slot_rank [DISP_SIZE];
  alu_issue_t            w_issue_next [ALU_INST_NUM];
  alu_issue_t            r_issue [ALU_INST_NUM];

  // --------------------
  // Slot filter
  // --------------------
  always_comb begin
    for (int d = 0; d < DISP_SIZE; d++) begin
      w_alu_slot[d] = i_disp[d].valid & ~i_disp[d].illegal & (i_disp[d].cat == CAT_ALU);
    end
  end

  // Number of ALU slots ahead of each slot
  always_comb begin
    logic [DISP_CNT_W-1:0] l_cnt;
    l_cnt = '0;
    for (int d = 0; d < DISP_SIZE; d++) begin
      w_slot_rank[d] = l_cnt;
      l_cnt = l_cnt + DISP_CNT_W'(w_alu_slot[d]);
    end
  end

  // --------------------
  // Pipe select
  // --------------------
  // k-th ALU slot of the group goes to pipe k
  always_comb begin
    for (int k = 0; k < ALU_INST_NUM; k++) begin
      w_issue_next[k] = '0;
      for (int d = 0; d < DISP_SIZE; d++) begin
        if (w_alu_slot[d] && (w_slot_rank[d] == DISP_CNT_W'(k))) begin
          w_issue_next[k].valid  = 1'b1;
          w_issue_next[k].op     = i_disp[d].op;
          w_issue_next[k].rs1    = i_disp[d].rs1;
          w_issue_next[k].rs2    = i_disp[d].rs2;
          w_issue_next[k].rd     = i_disp[d].rd;
          w_issue_next[k].cmt_id = i_disp[d].cmt_id;
        end
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      r_issue <= '{default: '0};
    end else begin
      r_issue <= w_issue_next;
    end
  end

  assign o_issue = r_issue;

endmodule

`default_nettype wire

// File: alu/alu_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module alu_pipe (
  input  logic                  i_clk,
  input  logic                  i_rst_n,
  input  tile_pkg::alu_issue_t  i_issue,
  output tile_pkg::rnid_t       o_rs1_rnid,
  output tile_pkg::rnid_t       o_rs2_rnid,
  input  tile_pkg::data_t       i_rs1_data,
  input  tile_pkg::data_t       i_rs2_data,
  output tile_pkg::phy_wr_t     o_phy_wr,
  output tile_pkg::done_rpt_t   o_done_rpt
);

  import tile_pkg::*;
  import tile_conf_pkg::*;

  data_t   w_result;
  logic    w_slt;

  logic    r_valid;
  rnid_t   r_rd;
  cmt_id_t r_cmt_id;
  data_t   r_data;

  // --------------------
  // Operand read
  // --------------------
  // Register file answers in the same cycle
  assign o_rs1_rnid = i_issue.rs1;
  assign o_rs2_rnid = i_issue.rs2;

  // --------------------
  // Execute
  // --------------------
  assign w_slt = $signed(i_rs1_data) < $signed(i_rs2_data);

  always_comb begin
    case (i_issue.op)
      OP_ADD:  w_result = i_rs1_data + i_rs2_data;
      OP_SUB:  w_result = i_rs1_data - i_rs2_data;
      OP_AND:  w_result = i_rs1_data & i_rs2_data;
      OP_OR:   w_result = i_rs1_data | i_rs2_data;
      OP_XOR:  w_result = i_rs1_data ^ i_rs2_data;
      OP_SLT:  w_result = {{(XLEN-1){1'b0}}, w_slt};
      default: w_result = '0;
    endcase
  end

  // --------------------
  // Output register
  // --------------------
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      r_valid <= 1'b0;
    end else begin
      r_valid <= i_issue.valid;
    end
  end

  always_ff @(posedge i_clk) begin
    r_rd     <= i_issue.rd;
    r_cmt_id <= i_issue.cmt_id;
    r_data   <= w_result;
  end

  // Same result feeds the write port and the done report
  assign o_phy_wr.valid = r_valid;
  assign o_phy_wr.rd    = r_rd;
  assign o_phy_wr.data  = r_data;

  assign o_done_rpt.valid  = r_valid;
  assign o_done_rpt.cmt_id = r_cmt_id;
  assign o_done_rpt.rd     = r_rd;
  assign o_done_rpt.data   = r_data;

endmodule

`default_nettype wire

// File: logic/phy_registers.sv
`timescale 1ns/1ps
`default_nettype none

module phy_registers (
  input  logic               i_clk,
  input  logic               i_rst_n,
  input  tile_pkg::phy_wr_t  i_wr      [tile_conf_pkg::WR_PORT_NUM],
  input  tile_pkg::rnid_t    i_rd_rnid [tile_conf_pkg::RD_PORT_NUM],
  output tile_pkg::data_t    o_rd_data [tile_conf_pkg::RD_PORT_NUM]
);

  import tile_pkg::*;
  import tile_conf_pkg::*;

  data_t                  r_regs    [PHY_REG_NUM];
  logic [PHY_REG_NUM-1:0] w_wr_hit;
  data_t                  w_wr_data [PHY_REG_NUM];

  // --------------------
  // Write merge
  // --------------------
  // Later ports override earlier ones, so the load port wins
  always_comb begin
    w_wr_hit  = '0;
    w_wr_data = '{default: '0};
    for (int r = 1; r < PHY_REG_NUM; r++) begin
      for (int w = 0; w < WR_PORT_NUM; w++) begin
        if (i_wr[w].valid && (i_wr[w].rd == rnid_t'(r))) begin
          w_wr_hit[r]  = 1'b1;
          w_wr_data[r] = i_wr[w].data;
        end
      end
    end
  end

  // --------------------
  // Register array
  // --------------------
  // Entry 0 is never written and stays zero
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      r_regs <= '{default: '0};
    end else begin
      for (int r = 1; r < PHY_REG_NUM; r++) begin
        if (w_wr_hit[r]) begin
          r_regs[r] <= w_wr_data[r];
        end
      end
    end
  end

  // --------------------
  // Read with bypass
  // --------------------
  always_comb begin
    for (int p = 0; p < RD_PORT_NUM; p++) begin
      if (i_rd_rnid[p] == '0) begin
        o_rd_data[p] = '0;
      end else if (w_wr_hit[i_rd_rnid[p]]) begin
        // Write in flight this cycle
        o_rd_data[p] = w_wr_data[i_rd_rnid[p]];
      end else begin
        o_rd_data[p] = r_regs[i_rd_rnid[p]];
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/int_tile.sv
`timescale 1ns/1ps
`default_nettype none

module int_tile (
  input  logic                 i_clk,
  input  logic                 i_rst_n,
  input  tile_pkg::disp_grp_t  i_disp,
  input  tile_pkg::phy_wr_t    i_ld_wr,
  output tile_pkg::done_rpt_t  o_done_rpt [tile_conf_pkg::ALU_INST_NUM]
);

  import tile_pkg::*;
  import tile_conf_pkg::*;

  alu_issue_t w_issue   [ALU_INST_NUM];
  rnid_t      w_rd_rnid [RD_PORT_NUM];
  data_t      w_rd_data [RD_PORT_NUM];
  phy_wr_t    w_wr      [WR_PORT_NUM];

  // --------------------
  // Dispatch routing
  // --------------------
  disp_router u_disp_router (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_disp  (i_disp),
    .o_issue (w_issue)
  );

  // --------------------
  // ALU pipes
  // --------------------
  // Pipe k owns read ports 2k, 2k+1 and write port k
  generate for (genvar alu_idx = 0; alu_idx < ALU_INST_NUM; alu_idx++) begin : alu_loop
    alu_pipe u_alu_pipe (
      .i_clk      (i_clk),
      .i_rst_n    (i_rst_n),
      .i_issue    (w_issue[alu_idx]),
      .o_rs1_rnid (w_rd_rnid[alu_idx * 2 + 0]),
      .o_rs2_rnid (w_rd_rnid[alu_idx * 2 + 1]),
      .i_rs1_data (w_rd_data[alu_idx * 2 + 0]),
      .i_rs2_data (w_rd_data[alu_idx * 2 + 1]),
      .o_phy_wr   (w_wr[alu_idx]),
      .o_done_rpt (o_done_rpt[alu_idx])
    );
  end
  endgenerate

  // Load return sits above the pipes in write priority
  assign w_wr[WR_PORT_NUM-1] = i_ld_wr;

  // --------------------
  // Register file
  // --------------------
  phy_registers u_phy_registers (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .i_wr      (w_wr),
    .i_rd_rnid (w_rd_rnid),
    .o_rd_data (w_rd_data)
  );

endmodule

`default_nettype wire

// File: test/tb_int_tile_tests.svh
`ifndef TB_INT_TILE_TESTS_SVH
`define TB_INT_TILE_TESTS_SVH

task automatic check_after_reset();
  disp_grp_t grp;
  start_test("reset");
  grp    = '0;
  grp[0] = alu_inst(OP_ADD, 1, 2, 3, next_cmt());
  tick('0, '0);
  tick(grp, '0);
  flush_pipes();
  finish_test();
endtask

task automatic exercise_opcodes();
  disp_grp_t grp;
  int        i;
  start_test("opcodes");
  // Operand pairs with both signs for the compare
  tick('0, load_wr(1, $urandom()));
  tick('0, load_wr(2, $urandom() | 32'h8000_0000));
  tick('0, load_wr(3, $urandom() & 32'h7fff_ffff));
  tick('0, load_wr(4, 32'hffff_fffe));
  for (i = 0; i < 6; i++) begin
    grp[0] = alu_inst(alu_op_t'(i), 1, 2, rnid_t'(8 + i), next_cmt());
    grp[1] = alu_inst(alu_op_t'(i), 3, 4, rnid_t'(16 + i), next_cmt());
    tick(grp, '0);
  end
  flush_pipes();
  finish_test();
endtask

task automatic mixed_category_routing();
  disp_grp_t grp;
  start_test("routing");
  grp[0]     = alu_inst(OP_ADD, 1, 2, 20, next_cmt());
  grp[1]     = alu_inst(OP_SUB, 3, 4, 21, next_cmt());
  grp[0].cat = CAT_LD;
  tick(grp, '0);
  grp[0].cat = CAT_ALU;
  grp[1].cat = CAT_BR;
  tick(grp, '0);
  grp[0].illegal = 1'b1;
  grp[1].cat     = CAT_ALU;
  tick(grp, '0);
  grp[0].illegal = 1'b0;
  grp[0].valid   = 1'b0;
  tick(grp, '0);
  // Nothing for either pipe
  grp[0].valid = 1'b1;
  grp[0].cat   = CAT_ST;
  grp[1].cat   = CAT_CSU;
  tick(grp, '0);
  grp[0].cat = CAT_ALU;
  grp[1].cat = CAT_ALU;
  tick(grp, '0);
  flush_pipes();
  finish_test();
endtask

task automatic dependent_chain();
  disp_grp_t grp;
  int        i;
  start_test("chain");
  tick('0, load_wr(1, 32'h0000_0011));
  // Each group reads results of the group right before it
  for (i = 0; i < 6; i++) begin
    grp[0] = alu_inst(OP_ADD, 5, 1, 5, next_cmt());
    grp[1] = alu_inst(OP_XOR, 6, 5, 6, next_cmt());
    tick(grp, '0);
  end
  flush_pipes();
  finish_test();
endtask

task automatic zero_reg_and_priority();
  disp_grp_t grp;
  start_test("zero_priority");
  grp[0] = alu_inst(OP_OR, 1, 2, 0, next_cmt());
  grp[1] = alu_inst(OP_ADD, 3, 4, 0, next_cmt());
  tick(grp, load_wr(0, 32'hdead_beef));
  // Reads r0 while the pipes write it
  grp[0] = alu_inst(OP_ADD, 1, 0, 11, next_cmt());
  grp[1] = alu_inst(OP_OR, 1, 2, 12, next_cmt());
  tick(grp, '0);
  tick('0, '0);
  // Load meets the pipe 1 write of r12 on the same edge
  tick('0, load_wr(12, 32'h1234_5678));
  grp[0] = alu_inst(OP_ADD, 12, 0, 13, next_cmt());
  grp[1] = alu_inst(OP_OR, 0, 0, 14, next_cmt());
  tick(grp, '0);
  flush_pipes();
  finish_test();
endtask

task automatic random_stream();
  disp_grp_t grp;
  phy_wr_t   ld;
  int        i;
  int        d;
  start_test("random");
  for (i = 0; i < 60; i++) begin
    for (d = 0; d < DISP_SIZE; d++) begin
      grp[d] = alu_inst(alu_op_t'($urandom_range(5)), rnid_t'($urandom_range(31)),
                        rnid_t'($urandom_range(31)), rnid_t'($urandom_range(31)),
                        next_cmt());
      grp[d].valid = ($urandom_range(3) != 0);
    end
    ld = '0;
    if ($urandom_range(3) == 0) begin
      ld = load_wr(rnid_t'($urandom_range(31)), $urandom());
    end
    tick(grp, ld);
  end
  flush_pipes();
  finish_test();
endtask

`endif

// File: test/tb_int_tile.sv
`timescale 1ns/1ps
`default_nettype none

module tb_int_tile;

  import tile_pkg::*;
  import tile_conf_pkg::*;

  logic        clk = 1'b0;
  logic        rst_n;
  disp_grp_t   disp;
  phy_wr_t     ld_wr;
  done_rpt_t   done_rpt [ALU_INST_NUM];

  // Reference state
  data_t       model_regs [PHY_REG_NUM];
  alu_issue_t  issued     [ALU_INST_NUM];
  done_rpt_t   exp_done   [ALU_INST_NUM];
  cmt_id_t     cmt_ctr;
  string       test_name;
  int          test_err_base;
  int          checks;
  int          errors;
  int          cycle_cnt = 0;
  // Reset and tests take about 120 cycles
  int          cycle_limit = 400;

  always #20 clk = ~clk;

  int_tile int_tile_i (
    .i_clk      (clk),
    .i_rst_n    (rst_n),
    .i_disp     (disp),
    .i_ld_wr    (ld_wr),
    .o_done_rpt (done_rpt)
  );

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Checks failed");
      $finish;
    end
  end

  // --------------------
  // Reference helpers
  // --------------------
  function automatic data_t alu_ref(input alu_op_t op, input data_t a, input data_t b);
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_OR:   return a | b;
      OP_XOR:  return a ^ b;
      OP_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      default: return '0;
    endcase
  endfunction

  function automatic disp_inst_t alu_inst(input alu_op_t op, input rnid_t rs1,
                                          input rnid_t rs2, input rnid_t rd,
                                          input cmt_id_t id);
    disp_inst_t inst;
    inst        = '0;
    inst.valid  = 1'b1;
    inst.cat    = CAT_ALU;
    inst.op     = op;
    inst.rs1    = rs1;
    inst.rs2    = rs2;
    inst.rd     = rd;
    inst.cmt_id = id;
    return inst;
  endfunction

  function automatic phy_wr_t load_wr(input rnid_t rd, input data_t data);
    phy_wr_t wr;
    wr.valid = 1'b1;
    wr.rd    = rd;
    wr.data  = data;
    return wr;
  endfunction

  function automatic cmt_id_t next_cmt();
    cmt_ctr = cmt_ctr + 1'b1;
    return cmt_ctr;
  endfunction

  task automatic start_test(input string name);
    test_name     = name;
    test_err_base = errors;
  endtask

  task automatic finish_test();
    $display("Test %s finished with %0d errors", test_name, errors - test_err_base);
  endtask

  task automatic report_mismatch(input int pipe);
    errors++;
    $display("Error %s pipe %0d: expected %h, actual %h", test_name, pipe,
             exp_done[pipe], done_rpt[pipe]);
  endtask

  // --------------------
  // One cycle
  // --------------------
  task automatic tick(input disp_grp_t grp, input phy_wr_t ld);
    int p;
    int d;
    @(negedge clk);
    // Reports on the outputs now belong to the group from two cycles back
    for (p = 0; p < ALU_INST_NUM; p++) begin
      checks++;
      if (done_rpt[p].valid !== exp_done[p].valid) begin
        report_mismatch(p);
      end else if (exp_done[p].valid && (done_rpt[p] !== exp_done[p])) begin
        report_mismatch(p);
      end
    end
    // Writes on the coming edge, pipes in order and the load port last
    for (p = 0; p < ALU_INST_NUM; p++) begin
      if (exp_done[p].valid && (exp_done[p].rd != '0)) begin
        model_regs[exp_done[p].rd] = exp_done[p].data;
      end
    end
    if (ld.valid && (ld.rd != '0)) begin
      model_regs[ld.rd] = ld.data;
    end
    // Group issued last cycle sees those writes through the bypass
    for (p = 0; p < ALU_INST_NUM; p++) begin
      exp_done[p] = '0;
      if (issued[p].valid) begin
        exp_done[p].valid  = 1'b1;
        exp_done[p].cmt_id = issued[p].cmt_id;
        exp_done[p].rd     = issued[p].rd;
        exp_done[p].data   = alu_ref(issued[p].op, model_regs[issued[p].rs1],
                                     model_regs[issued[p].rs2]);
      end
    end
    // k-th legal ALU slot goes to pipe k
    issued = '{default: '0};
    p = 0;
    for (d = 0; d < DISP_SIZE; d++) begin
      if (grp[d].valid && !grp[d].illegal && (grp[d].cat == CAT_ALU) && (p < ALU_INST_NUM)) begin
        issued[p].valid  = 1'b1;
        issued[p].op     = grp[d].op;
        issued[p].rs1    = grp[d].rs1;
        issued[p].rs2    = grp[d].rs2;
        issued[p].rd     = grp[d].rd;
        issued[p].cmt_id = grp[d].cmt_id;
        p++;
      end
    end
    disp  = grp;
    ld_wr = ld;
  endtask

  task automatic flush_pipes();
    tick('0, '0);
    tick('0, '0);
  endtask

  `include "tb_int_tile_tests.svh"

  initial begin
    void'($urandom(53238));
    rst_n      = 1'b0;
    disp       = '0;
    ld_wr      = '0;
    model_regs = '{default: '0};
    issued     = '{default: '0};
    exp_done   = '{default: '0};
    cmt_ctr    = '0;
    checks     = 0;
    errors     = 0;
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    check_after_reset();
    exercise_opcodes();
    mixed_category_routing();
    dependent_chain();
    zero_reg_and_priority();
    random_stream();
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
+incdir+test
common/tile_conf_pkg.sv
common/tile_pkg.sv
logic/disp_router.sv
alu/alu_pipe.sv
logic/phy_registers.sv
logic/int_tile.sv
test/tb_int_tile.sv

// File: Bender.yml
package:
  name: int_tile

sources:
  - files:
      - common/tile_conf_pkg.sv
      - common/tile_pkg.sv
      - logic/disp_router.sv
      - alu/alu_pipe.sv
      - logic/phy_registers.sv
      - logic/int_tile.sv
  - target: simulation
    include_dirs:
      - test
    files:
      - test/tb_int_tile.sv
